//--- design/z80fi_consts.svh
// Constants shared by the CB rotate retirement checker.
// Include this header in any design file that decodes a CB opcode or
// builds an expected flag byte. It holds definitions only.

`ifndef Z80FI_CONSTS_SVH
`define Z80FI_CONSTS_SVH

// Bit positions inside the F register.
// The order follows the Z80 data book, carry in bit 0 and sign in bit 7.
`define FLAG_C_NUM 0
`define FLAG_N_NUM 1
`define FLAG_V_NUM 2
`define FLAG_3_NUM 3
`define FLAG_H_NUM 4
`define FLAG_5_NUM 5
`define FLAG_Z_NUM 6
`define FLAG_S_NUM 7

// First byte of every CB-prefixed instruction.
`define CB_PREFIX 8'hCB

// The x field of the CB opcode selects the group.
// Group 0 holds the rotates and the shifts, and y tells them apart.
`define CB_X_ROT 2'b00

// A z field of 6 names the memory operand (HL) instead of a register.
`define Z_IND_HL 3'd6

// Length in bytes of an unindexed CB instruction.
`define INSN_LEN_CB 3'd2

// Amount the instruction pointer moves past a CB instruction.
// It matches the instruction length above.
`define IP_STEP_CB 16'd2

`endif

//--- design/z80fi_pkg.sv
// Types for the CB rotate retirement checker.
// Every module of the checker refers to these by scoped name.

`default_nettype none

package z80fi_pkg;

    // Field split of a CB instruction as it sits in the trace word.
    // The prefix takes the lowest byte and the opcode the byte above it.
    // Inside y, bit 1 selects rotate through carry and bit 0 selects right.
    typedef struct packed {
        logic [15:0] unused;
        logic [1:0]  x;
        logic [2:0]  y;
        logic [2:0]  z;
        logic [7:0]  prefix;
    } cb_fields_t;

    // The instruction word is read either as raw bytes or as CB fields.
    typedef union packed {
        logic [3:0][7:0] bytes;
        cb_fields_t      cb;
    } insn_u;

    // The seven 8-bit registers that a CB rotate can touch.
    typedef struct packed {
        logic [7:0] b;
        logic [7:0] c;
        logic [7:0] d;
        logic [7:0] e;
        logic [7:0] h;
        logic [7:0] l;
        logic [7:0] a;
    } regs_t;

    // One retired instruction as reported by the core or a trace player.
    typedef struct packed {
        insn_u       insn;
        logic [2:0]  insn_len;
        logic [15:0] ip_in;
        logic [15:0] ip_out;
        logic [7:0]  f_in;
        logic [7:0]  f_out;
        regs_t       regs_in;
        regs_t       regs_out;
        logic        mem_rd;
        logic        mem_wr;
        logic [15:0] bus_raddr;
        logic [15:0] bus_waddr;
        logic [7:0]  bus_rdata;
        logic [7:0]  bus_wdata;
    } trace_t;

    // What a spec block expects the instruction to have done.
    // The fields are only meaningful while valid is set.
    typedef struct packed {
        logic        valid;
        logic [15:0] ip_out;
        logic [7:0]  f_out;
        regs_t       regs_out;
        logic        mem_rd;
        logic        mem_wr;
        logic [15:0] bus_raddr;
        logic [15:0] bus_waddr;
        logic [7:0]  bus_wdata;
    } spec_t;

    // One bit per compared field, set when the record disagrees.
    typedef struct packed {
        logic ip;
        logic flags;
        logic regs;
        logic mem_ctl;
        logic raddr;
        logic waddr;
        logic wdata;
    } mismatch_t;

endpackage

`default_nettype wire

//--- design/z80fi_trace_capture.sv
// Input register stage of the CB rotate checker.
// Every strobed trace record is taken in here, one cycle before the spec
// blocks and the comparator look at it.

`timescale 1ns/1ps
`default_nettype none

module z80fi_trace_capture (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    trace_valid,
    input  wire z80fi_pkg::trace_t trace,
    output logic                   cap_valid,
    output z80fi_pkg::trace_t      cap_trace
);

    // The strobe is control state and is cleared on reset.
    // A record may follow its predecessor on the very next cycle, so the
    // strobe is copied every cycle with no hold.
    always_ff @(posedge clk) begin
        if (rst) begin
            cap_valid <= 1'b0;
        end else begin
            cap_valid <= trace_valid;
        end
    end

    // The record itself is payload.
    // It only loads on a strobe and keeps the last record otherwise, which
    // keeps the spec logic quiet between records.
    always_ff @(posedge clk) begin
        if (trace_valid) begin
            cap_trace <= trace;
        end
    end

    // A Z80 instruction is one to four bytes long.
    // Anything else means the trace source is broken, not the core.
    // The check is made on the captured copy that the spec blocks see.
    a_legal_insn_len: assert property (
        @(posedge clk) disable iff (rst)
        cap_valid |-> (cap_trace.insn_len >= 3'd1 && cap_trace.insn_len <= 3'd4)
    ) else $error("trace record with illegal instruction length");

endmodule

`default_nettype wire

//--- design/z80fi_insn_spec_rot_ind_hl.sv
// Expected outcome of RLC, RRC, RL and RR on the byte at (HL).
// Purely combinational. It looks at the captured record and raises
// spec.valid only when the record holds one of these four opcodes.

`timescale 1ns/1ps
`default_nettype none

`include "z80fi_consts.svh"

module z80fi_insn_spec_rot_ind_hl (
    input  wire z80fi_pkg::trace_t cap_trace,
    output z80fi_pkg::spec_t       spec
);

    z80fi_pkg::insn_u insn;
    logic             through_c;
    logic             right;
    logic             match;
    logic             shove_bit;
    logic [7:0]       rdata;
    logic [7:0]       wdata;
    logic [7:0]       f_exp;
    logic [15:0]      hl;

    assign insn = cap_trace.insn;

    // Bit 1 of y makes the rotate go through carry (RL, RR).
    // Bit 0 of y makes it go right (RRC, RR).
    assign through_c = insn.cb.y[1];
    assign right     = insn.cb.y[0];

    // Rotates only use y from 0 to 3, so the top bit of y must be clear.
    // Shifts live at y from 4 to 7 and are left to the unsupported path.
    assign match = (insn.bytes[0] == `CB_PREFIX) &&
                   (insn.cb.x == `CB_X_ROT) &&
                   !insn.cb.y[2] &&
                   (insn.cb.z == `Z_IND_HL) &&
                   (cap_trace.insn_len == `INSN_LEN_CB);

    // The operand is the byte the core read from memory at HL.
    assign rdata = cap_trace.bus_rdata;
    assign hl    = {cap_trace.regs_in.h, cap_trace.regs_in.l};

    // This bit enters the byte at the far end.
    // Through carry it is the old carry, so the rotate is nine bits wide.
    // Otherwise it is the bit that falls off the other end.
    assign shove_bit = through_c ? cap_trace.f_in[`FLAG_C_NUM] : rdata[right ? 0 : 7];
    assign wdata     = right ? {shove_bit, rdata[7:1]} : {rdata[6:0], shove_bit};

    // Flags of a CB rotate.
    always_comb begin
        f_exp              = 8'h00;
        f_exp[`FLAG_S_NUM] = wdata[7];
        f_exp[`FLAG_Z_NUM] = (wdata == 8'h00);
        // Bits 5 and 3 are not touched by the rotate.
        f_exp[`FLAG_5_NUM] = cap_trace.f_in[`FLAG_5_NUM];
        f_exp[`FLAG_3_NUM] = cap_trace.f_in[`FLAG_3_NUM];
        f_exp[`FLAG_H_NUM] = 1'b0;
        f_exp[`FLAG_N_NUM] = 1'b0;
        // P/V is set for even parity of the result.
        f_exp[`FLAG_V_NUM] = ~^wdata;
        // Carry always takes the bit shifted out, in all four forms.
        f_exp[`FLAG_C_NUM] = rdata[right ? 0 : 7];
    end

    // The byte is read from HL and written back to HL.
    // No register changes, since the result only goes to memory.
    always_comb begin
        spec.valid     = match;
        spec.ip_out    = cap_trace.ip_in + `IP_STEP_CB;
        spec.f_out     = f_exp;
        spec.regs_out  = cap_trace.regs_in;
        spec.mem_rd    = 1'b1;
        spec.mem_wr    = 1'b1;
        spec.bus_raddr = hl;
        spec.bus_waddr = hl;
        spec.bus_wdata = wdata;
    end

endmodule

`default_nettype wire

//--- design/z80fi_insn_spec_rot_reg.sv
// Expected outcome of RLC, RRC, RL and RR on a register.
// Covers B, C, D, E, H, L and A. Purely combinational, and spec.valid
// is raised only for a matching register-form opcode.

`timescale 1ns/1ps
`default_nettype none

`include "z80fi_consts.svh"

module z80fi_insn_spec_rot_reg (
    input  wire z80fi_pkg::trace_t cap_trace,
    output z80fi_pkg::spec_t       spec
);

    z80fi_pkg::insn_u insn;
    logic             through_c;
    logic             right;
    logic             match;
    logic             shove_bit;
    logic [7:0]       src;
    logic [7:0]       result;
    logic [7:0]       f_exp;

    assign insn      = cap_trace.insn;
    assign through_c = insn.cb.y[1];
    assign right     = insn.cb.y[0];

    // Same opcode pattern as the (HL) form, but with a register in z.
    assign match = (insn.bytes[0] == `CB_PREFIX) &&
                   (insn.cb.x == `CB_X_ROT) &&
                   !insn.cb.y[2] &&
                   (insn.cb.z != `Z_IND_HL) &&
                   (cap_trace.insn_len == `INSN_LEN_CB);

    // Source register in the usual Z80 order, B C D E H L (HL) A.
    // Slot 6 is the memory form and never matches here.
    always_comb begin
        case (insn.cb.z)
            3'd0:    src = cap_trace.regs_in.b;
            3'd1:    src = cap_trace.regs_in.c;
            3'd2:    src = cap_trace.regs_in.d;
            3'd3:    src = cap_trace.regs_in.e;
            3'd4:    src = cap_trace.regs_in.h;
            3'd5:    src = cap_trace.regs_in.l;
            3'd7:    src = cap_trace.regs_in.a;
            default: src = 8'h00;
        endcase
    end

    // Old carry for RL and RR, otherwise the bit that leaves the byte.
    assign shove_bit = through_c ? cap_trace.f_in[`FLAG_C_NUM] : src[right ? 0 : 7];
    assign result    = right ? {shove_bit, src[7:1]} : {src[6:0], shove_bit};

    // Flag rules are the same as for the memory form.
    always_comb begin
        f_exp              = 8'h00;
        f_exp[`FLAG_S_NUM] = result[7];
        f_exp[`FLAG_Z_NUM] = (result == 8'h00);
        f_exp[`FLAG_5_NUM] = cap_trace.f_in[`FLAG_5_NUM];
        f_exp[`FLAG_3_NUM] = cap_trace.f_in[`FLAG_3_NUM];
        f_exp[`FLAG_V_NUM] = ~^result;
        f_exp[`FLAG_C_NUM] = src[right ? 0 : 7];
    end

    always_comb begin
        spec.valid    = match;
        spec.ip_out   = cap_trace.ip_in + `IP_STEP_CB;
        spec.f_out    = f_exp;
        // Only the selected register takes the result.
        spec.regs_out = cap_trace.regs_in;
        case (insn.cb.z)
            3'd0:    spec.regs_out.b = result;
            3'd1:    spec.regs_out.c = result;
            3'd2:    spec.regs_out.d = result;
            3'd3:    spec.regs_out.e = result;
            3'd4:    spec.regs_out.h = result;
            3'd5:    spec.regs_out.l = result;
            3'd7:    spec.regs_out.a = result;
            default: spec.regs_out = cap_trace.regs_in;
        endcase
        // No bus traffic, so the bus fields stay zero and go uncompared.
        spec.mem_rd    = 1'b0;
        spec.mem_wr    = 1'b0;
        spec.bus_raddr = 16'h0000;
        spec.bus_waddr = 16'h0000;
        spec.bus_wdata = 8'h00;
    end

endmodule

`default_nettype wire

//--- design/z80fi_spec_check.sv
// Output stage of the CB rotate checker.
// Picks the spec block that claims the record, compares every field and
// registers one verdict per captured record.

`timescale 1ns/1ps
`default_nettype none

module z80fi_spec_check (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    cap_valid,
    input  wire z80fi_pkg::trace_t cap_trace,
    input  wire z80fi_pkg::spec_t  spec_hl,
    input  wire z80fi_pkg::spec_t  spec_reg,
    output logic                   check_valid,
    output logic                   check_pass,
    output logic                   check_fail,
    output logic                   unsupported,
    output z80fi_pkg::mismatch_t   mismatch
);

    z80fi_pkg::spec_t     sel;
    z80fi_pkg::mismatch_t mm_next;
    logic                 any_valid;

    // At most one spec block can claim a record, so a plain priority
    // select is enough.
    assign sel       = spec_hl.valid ? spec_hl : spec_reg;
    assign any_valid = spec_hl.valid | spec_reg.valid;

    always_comb begin
        mm_next         = '0;
        mm_next.ip      = (cap_trace.ip_out != sel.ip_out);
        mm_next.flags   = (cap_trace.f_out != sel.f_out);
        mm_next.regs    = (cap_trace.regs_out != sel.regs_out);
        mm_next.mem_ctl = (cap_trace.mem_rd != sel.mem_rd) ||
                          (cap_trace.mem_wr != sel.mem_wr);
        // Bus fields only count when the spec expects that access.
        mm_next.raddr   = sel.mem_rd && (cap_trace.bus_raddr != sel.bus_raddr);
        mm_next.waddr   = sel.mem_wr && (cap_trace.bus_waddr != sel.bus_waddr);
        mm_next.wdata   = sel.mem_wr && (cap_trace.bus_wdata != sel.bus_wdata);
        // An unsupported record reports no mismatch at all.
        if (!any_valid) begin
            mm_next = '0;
        end
    end

    // Verdict register.
    // The pulses and the mismatch word are zero between verdicts.
    always_ff @(posedge clk) begin
        if (rst) begin
            check_valid <= 1'b0;
            check_pass  <= 1'b0;
            check_fail  <= 1'b0;
            unsupported <= 1'b0;
            mismatch    <= '0;
        end else begin
            check_valid <= cap_valid;
            check_pass  <= cap_valid && any_valid && (mm_next == '0);
            check_fail  <= cap_valid && any_valid && (|mm_next);
            unsupported <= cap_valid && !any_valid;
            mismatch    <= cap_valid ? mm_next : '0;
        end
    end

    // The two opcode patterns differ only in z, so they must never overlap.
    a_single_spec: assert property (
        @(posedge clk) disable iff (rst)
        cap_valid |-> !(spec_hl.valid && spec_reg.valid)
    ) else $error("both rotate spec blocks claim the same record");

    // Each verdict carries exactly one outcome, and none appears without it.
    a_one_outcome: assert property (
        @(posedge clk) disable iff (rst)
        check_valid ? $onehot({check_pass, check_fail, unsupported})
                    : !(check_pass || check_fail || unsupported)
    ) else $error("verdict outcome pulses are not one-hot");

endmodule

`default_nettype wire

//--- design/z80fi_cb_rot_checker.sv
// Top level of the CB rotate retirement checker.
// A strobed trace record gives a verdict exactly two cycles later,
// with one mismatch bit per compared field.

`timescale 1ns/1ps
`default_nettype none

module z80fi_cb_rot_checker (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    trace_valid,
    input  wire z80fi_pkg::trace_t trace,
    output logic                   check_valid,
    output logic                   check_pass,
    output logic                   check_fail,
    output logic                   unsupported,
    output z80fi_pkg::mismatch_t   mismatch
);

    logic              cap_valid;
    z80fi_pkg::trace_t cap_trace;
    z80fi_pkg::spec_t  spec_hl;
    z80fi_pkg::spec_t  spec_reg;

    // First cycle, the record is registered.
    z80fi_trace_capture u_capture (
        .clk         (clk),
        .rst         (rst),
        .trace_valid (trace_valid),
        .trace       (trace),
        .cap_valid   (cap_valid),
        .cap_trace   (cap_trace)
    );

    // Both spec blocks look at the same captured record.
    z80fi_insn_spec_rot_ind_hl u_spec_hl (
        .cap_trace (cap_trace),
        .spec      (spec_hl)
    );

    z80fi_insn_spec_rot_reg u_spec_reg (
        .cap_trace (cap_trace),
        .spec      (spec_reg)
    );

    // Second cycle, the verdict is registered.
    z80fi_spec_check u_check (
        .clk         (clk),
        .rst         (rst),
        .cap_valid   (cap_valid),
        .cap_trace   (cap_trace),
        .spec_hl     (spec_hl),
        .spec_reg    (spec_reg),
        .check_valid (check_valid),
        .check_pass  (check_pass),
        .check_fail  (check_fail),
        .unsupported (unsupported),
        .mismatch    (mismatch)
    );

endmodule

`default_nettype wire

//--- dv/z80fi_cb_rot_monitor.sv
// Scoreboard of the CB rotate checker testbench.
// It sees only the DUT ports. For every strobed record it predicts the
// verdict from the rotate rules, then checks the verdict and its latency.

`timescale 1ns/1ps
`default_nettype none

`include "z80fi_consts.svh"

module z80fi_cb_rot_monitor (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       trace_valid,
    input  wire z80fi_pkg::trace_t    trace,
    input  wire                       check_valid,
    input  wire                       check_pass,
    input  wire                       check_fail,
    input  wire                       unsupported,
    input  wire z80fi_pkg::mismatch_t mismatch,
    output int                        errors,
    output int                        verdicts
);

    // Expected verdict of one record and the cycle it is due on.
    // The outcome bits are pass, fail and unsupported in that order.
    typedef struct packed {
        logic [31:0]          due;
        logic [2:0]           outcome;
        z80fi_pkg::mismatch_t mm;
    } verdict_t;

    verdict_t    pending[$];
    int unsigned cycle;

    // Carry out in bit 8, result below it. y runs RLC, RRC, RL, RR.
    function automatic logic [8:0] rotate(input logic [7:0] d, input logic [1:0] y,
                                          input logic c);
        case (y)
            2'd0:    return {d[7], d[6:0], d[7]};
            2'd1:    return {d[0], d[0], d[7:1]};
            2'd2:    return {d[7], d[6:0], c};
            default: return {d[0], c, d[7:1]};
        endcase
    endfunction

    function automatic verdict_t predict(input z80fi_pkg::trace_t t);
        verdict_t        v;
        logic [7:0]      op;
        logic [6:0][7:0] bank;
        logic [2:0]      idx;
        logic [8:0]      rot;
        logic [7:0]      f;
        logic            hl_form;
        v       = '0;
        op      = t.insn.bytes[1];
        bank    = t.regs_in;
        hl_form = (op[2:0] == `Z_IND_HL);
        // Register A sits in the lowest byte, B in the highest.
        idx     = (op[2:0] == 3'd7) ? 3'd0 : 3'd6 - op[2:0];
        if (t.insn.bytes[0] != `CB_PREFIX || op[7:6] != `CB_X_ROT || op[5] ||
            t.insn_len != `INSN_LEN_CB) begin
            v.outcome = 3'b001;
            return v;
        end
        rot = rotate(hl_form ? t.bus_rdata : bank[idx], op[4:3], t.f_in[`FLAG_C_NUM]);
        f                  = 8'h00;
        f[`FLAG_S_NUM]     = rot[7];
        f[`FLAG_Z_NUM]     = (rot[7:0] == 8'h00);
        f[`FLAG_5_NUM]     = t.f_in[`FLAG_5_NUM];
        f[`FLAG_3_NUM]     = t.f_in[`FLAG_3_NUM];
        f[`FLAG_V_NUM]     = ~^rot[7:0];
        f[`FLAG_C_NUM]     = rot[8];
        v.mm.ip    = (t.ip_out != t.ip_in + `IP_STEP_CB);
        v.mm.flags = (t.f_out != f);
        if (hl_form) begin
            // Read and write back at HL, registers untouched.
            v.mm.regs    = (t.regs_out != t.regs_in);
            v.mm.mem_ctl = !(t.mem_rd && t.mem_wr);
            v.mm.raddr   = (t.bus_raddr != {t.regs_in.h, t.regs_in.l});
            v.mm.waddr   = (t.bus_waddr != {t.regs_in.h, t.regs_in.l});
            v.mm.wdata   = (t.bus_wdata != rot[7:0]);
        end else begin
            bank[idx]    = rot[7:0];
            v.mm.regs    = (t.regs_out != bank);
            v.mm.mem_ctl = t.mem_rd || t.mem_wr;
        end
        v.outcome = (v.mm == '0) ? 3'b100 : 3'b010;
        return v;
    endfunction

    // Inputs change on the falling edge and outputs are registered, so
    // both are stable here.
    always @(posedge clk) begin
        verdict_t exp_v;
        cycle = cycle + 1;
        if (rst) begin
            pending.delete();
        end else begin
            if (check_valid && pending.size() == 0) begin
                $display("Error at %0t: a verdict came with no record outstanding", $time);
                errors++;
            end else if (check_valid) begin
                exp_v = pending.pop_front();
                verdicts++;
                if (exp_v.due != cycle) begin
                    $display("Error at %0t: verdict due on cycle %0d came on cycle %0d",
                             $time, exp_v.due, cycle);
                    errors++;
                end
                if ({check_pass, check_fail, unsupported} != exp_v.outcome ||
                    mismatch != exp_v.mm) begin
                    $display("FAILED at %0t: outcome %b mismatch %b, expected %b %b", $time,
                             {check_pass, check_fail, unsupported}, mismatch,
                             exp_v.outcome, exp_v.mm);
                    errors++;
                end
            end else if (check_pass || check_fail || unsupported || mismatch != '0) begin
                $display("FAILED at %0t: verdict outputs set without check_valid", $time);
                errors++;
            end else if (pending.size() != 0 && pending[0].due < cycle) begin
                // The record was dropped. It still counts, so the run can end.
                $display("Error at %0t: no verdict for the record due on cycle %0d",
                         $time, pending[0].due);
                pending.delete(0);
                verdicts++;
                errors++;
            end
            if (trace_valid) begin
                exp_v     = predict(trace);
                exp_v.due = cycle + 2;
                pending.push_back(exp_v);
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_z80fi_cb_rot.sv
// Testbench of the CB rotate retirement checker.
// Drives random records, mostly correct rotates, some with one corrupted
// field and some outside the rotate family. The monitor checks each verdict.

`timescale 1ns/1ps
`default_nettype none

`include "z80fi_consts.svh"

module tb_z80fi_cb_rot;

    localparam int NUM_RECORDS  = 2000;
    localparam int RESET_CYCLES = 8;
    localparam int QUIET_CYCLES = 10;
    localparam int IDLE_BUDGET  = 200;
    localparam int SLACK_CYCLES = 20;
    // Reset, the quiet stretch, every record and idle cycle, then drain time.
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + QUIET_CYCLES + NUM_RECORDS +
                                    IDLE_BUDGET + SLACK_CYCLES;

    logic                 clk;
    logic                 rst;
    logic                 trace_valid;
    z80fi_pkg::trace_t    trace;
    logic                 check_valid;
    logic                 check_pass;
    logic                 check_fail;
    logic                 unsupported;
    z80fi_pkg::mismatch_t mismatch;
    int                   errors;
    int                   verdicts;
    logic [31:0]          rng;

    z80fi_cb_rot_checker uut (.*);

    z80fi_cb_rot_monitor u_monitor (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    task automatic draw(output logic [31:0] r);
        rng = xorshift32(rng);
        r   = rng;
    endtask

    // Fills in what a correct core reports for the rotate held in t.insn.
    function automatic z80fi_pkg::trace_t retire(input z80fi_pkg::trace_t t);
        logic [6:0][7:0] bank;
        logic [2:0]      idx;
        logic [7:0]      d;
        logic [7:0]      res;
        logic            in_bit;
        logic            right;
        right  = t.insn.cb.y[0];
        bank   = t.regs_in;
        idx    = (t.insn.cb.z == 3'd7) ? 3'd0 : 3'd6 - t.insn.cb.z;
        d      = (t.insn.cb.z == `Z_IND_HL) ? t.bus_rdata : bank[idx];
        // RL and RR shift in the old carry, which makes them nine-bit rotates.
        in_bit = t.insn.cb.y[1] ? t.f_in[0] : (right ? d[0] : d[7]);
        res    = right ? {in_bit, d[7:1]} : {d[6:0], in_bit};
        t.ip_out = t.ip_in + 16'd2;
        // S Z 5 H 3 P/V N C from bit 7 down; H and N clear, 5 and 3 kept.
        t.f_out  = {res[7], res == 8'h00, t.f_in[5], 1'b0, t.f_in[3], ~^res, 1'b0,
                    right ? d[0] : d[7]};
        t.mem_rd = (t.insn.cb.z == `Z_IND_HL);
        t.mem_wr = t.mem_rd;
        if (t.mem_rd) begin
            t.regs_out  = t.regs_in;
            t.bus_raddr = {t.regs_in.h, t.regs_in.l};
            t.bus_waddr = t.bus_raddr;
            t.bus_wdata = res;
        end else begin
            bank[idx]  = res;
            t.regs_out = bank;
        end
        return t;
    endfunction

    // One random record. Ten in sixteen are correct, four carry one bad
    // field and two fall outside the rotate family.
    task automatic make_record(output z80fi_pkg::trace_t t);
        logic [31:0]  w [8];
        logic [255:0] raw;
        logic [31:0]  rc;
        logic [2:0]   sel;
        logic [5:0]   pos;
        for (int i = 0; i < 8; i++) begin
            draw(w[i]);
        end
        draw(rc);
        raw = {w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]};
        t   = raw[$bits(z80fi_pkg::trace_t)-1:0];
        t.insn.cb.prefix = `CB_PREFIX;
        t.insn.cb.x      = `CB_X_ROT;
        t.insn.cb.y      = {1'b0, rc[1:0]};
        t.insn.cb.z      = rc[5] ? `Z_IND_HL : ((rc[4:2] == 3'd6) ? 3'd7 : rc[4:2]);
        t.insn_len       = `INSN_LEN_CB;
        t                = retire(t);
        sel              = rc[12:10];
        pos              = rc[21:16] % 6'd56;
        if (rc[9:6] >= 4'd14) begin
            // Wrong prefix, a shift, another CB group, or a wrong length.
            case (rc[11:10])
                2'd0:    t.insn.cb.prefix = (rc[31:24] == `CB_PREFIX) ? 8'hED : rc[31:24];
                2'd1:    t.insn.cb.y[2]   = 1'b1;
                2'd2:    t.insn.cb.x      = (rc[13:12] == 2'd0) ? 2'd1 : rc[13:12];
                default: t.insn_len       = rc[12] ? 3'd4 : (rc[13] ? 3'd3 : 3'd1);
            endcase
        end else if (rc[9:6] >= 4'd10) begin
            // Register forms have no bus fields worth corrupting.
            if (sel == 3'd7) begin
                sel = 3'd6;
            end
            if (!t.mem_rd && sel >= 3'd3 && sel <= 3'd5) begin
                sel = sel - 3'd3;
            end
            case (sel)
                3'd0:    t.ip_out[rc[19:16]]    = ~t.ip_out[rc[19:16]];
                3'd1:    t.f_out[rc[18:16]]     = ~t.f_out[rc[18:16]];
                3'd2:    t.regs_out[pos]        = ~t.regs_out[pos];
                3'd3:    t.bus_wdata[rc[18:16]] = ~t.bus_wdata[rc[18:16]];
                3'd4:    t.bus_waddr[rc[19:16]] = ~t.bus_waddr[rc[19:16]];
                3'd5:    t.bus_raddr[rc[19:16]] = ~t.bus_raddr[rc[19:16]];
                default: t.mem_wr               = ~t.mem_wr;
            endcase
        end
    endtask

    initial begin
        z80fi_pkg::trace_t rec;
        logic [31:0]       rc;
        int                sent;
        int                idles;
        rng         = 32'h34daa97a;
        rst         = 1'b1;
        trace_valid = 1'b0;
        trace       = '0;
        sent        = 0;
        idles       = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        // No strobes here, so every output has to stay zero.
        repeat (QUIET_CYCLES) @(negedge clk);
        while (sent < NUM_RECORDS) begin
            draw(rc);
            if (rc[3:0] == 4'd0 && idles < IDLE_BUDGET) begin
                trace_valid = 1'b0;
                idles++;
            end else begin
                make_record(rec);
                trace       = rec;
                trace_valid = 1'b1;
                sent++;
            end
            @(negedge clk);
        end
        trace_valid = 1'b0;
        while (verdicts < sent) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        $display("%0d records sent, %0d verdicts, %0d idle cycles, %0d errors",
                 sent, verdicts, idles, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+design
design/z80fi_pkg.sv
design/z80fi_trace_capture.sv
design/z80fi_insn_spec_rot_ind_hl.sv
design/z80fi_insn_spec_rot_reg.sv
design/z80fi_spec_check.sv
design/z80fi_cb_rot_checker.sv
dv/z80fi_cb_rot_monitor.sv
dv/tb_z80fi_cb_rot.sv

//--- Makefile
SIM := obj_dir/Vtb_z80fi_cb_rot

.PHONY: all run clean

all: run

$(SIM): flist.f $(wildcard design/*.sv design/*.svh dv/*.sv)
	verilator --binary --timing --assert -j 0 --top-module tb_z80fi_cb_rot -f flist.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "Test failures found" sim.log || ! grep -q "All tests passed!" sim.log; then \
		echo "Simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
